// File: list.f
i2s_pkg.sv
i2s_clock_gen.sv
i2s_receiver.sv
sample_buffer.sv
i2s_transmitter.sv
i2s_loopback_top.sv
tb_i2s_loopback.sv

// File: tb_i2s_loopback.sv
`timescale 1ns/100ps

module tb_i2s_loopback
    import i2s_pkg::*;
();

    // budget sized for the longest slots used, 24 bits at ratio 3
    localparam int     run_frames  = 80;
    localparam longint watchdog_ns = longint'(run_frames) * 2 * 24 * 2 * 3 * 100 + 100_000;

    logic   lmmi_clk_i;
    logic   arst_n;
    res_t   conf_res;
    ratio_t conf_ratio;
    logic   conf_swap;
    logic   conf_en;
    // codec line idles low until the first bit goes out
    logic   i2s_sd_i = 1'b0;
    logic   i2s_sd_o;
    logic   i2s_sck_o;
    logic   i2s_ws_o;
    logic   overflow;

    logic [31:0] lcg_state = 32'h9040036b;
    logic        quiet;
    sample_t     exp_q[$];
    int          slot_count;
    int          words_checked;
    logic        sck_q;
    logic        ws_q;
    // codec model
    sample_t     codec_word;
    int          codec_bit;
    sample_t     left_word;
    logic        left_held;
    // output monitor
    logic        mon_ws;
    sample_t     mon_acc;
    int          mon_bits;
    // bit clock and frame timing
    int          level_len;
    logic        level_known;
    int          fall_cnt;
    logic        ws_known;
    int          en_low_cnt;

    i2s_loopback_top UUT (
        .lmmi_clk_i (lmmi_clk_i),
        .arst_n     (arst_n),
        .conf_res   (conf_res),
        .conf_ratio (conf_ratio),
        .conf_swap  (conf_swap),
        .conf_en    (conf_en),
        .i2s_sd_i   (i2s_sd_i),
        .i2s_sd_o   (i2s_sd_o),
        .i2s_sck_o  (i2s_sck_o),
        .i2s_ws_o   (i2s_ws_o),
        .overflow   (overflow)
    );

    always #50 lmmi_clk_i = ~lmmi_clk_i;

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    // lcg step, top bits right-justified to the resolution, never zero
    function automatic sample_t next_word(input res_t res);
        sample_t word;
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        word = lcg_state >> (6'd32 - res);
        if (word == '0) begin
            word = sample_t'(1);
        end
        return word;
    endfunction

    // receiver order: swap sends right first, then the held left
    task automatic queue_expected(input sample_t word, input logic right);
        if (!conf_swap) begin
            if (word != '0) exp_q.push_back(word);
        end else if (!right) begin
            left_word = word;
            left_held = 1'b1;
        end else begin
            if (word != '0) exp_q.push_back(word);
            if (left_held && left_word != '0) exp_q.push_back(left_word);
            left_held = 1'b0;
        end
    endtask

    task automatic check_word(input sample_t got);
        sample_t exp;
        exp = (exp_q.size() != 0) ? exp_q.pop_front() : '0;
        words_checked <= words_checked + 1;
        assert (got == exp)
            else fail_now($sformatf("error i2s_sd_o word %h, expected %h", got, exp));
    endtask

    task automatic check_idle_outputs();
        assert (!i2s_sck_o && !i2s_ws_o && !i2s_sd_o && !overflow)
            else fail_now($sformatf("error i2s_sck_o %h i2s_ws_o %h i2s_sd_o %h overflow %h",
                                    i2s_sck_o, i2s_ws_o, i2s_sd_o, overflow));
    endtask

    task automatic wait_slots(input int n);
        int target;
        target = slot_count + n;
        while (slot_count < target) @(posedge lmmi_clk_i);
    endtask

    task automatic run_phase(input int slots);
        quiet <= 1'b0;
        wait_slots(slots);
        // zero words flush the pipeline and are skipped by the monitor
        quiet <= 1'b1;
        wait_slots(8);
        assert (exp_q.size() == 0)
            else fail_now($sformatf("%0d sent words never came back on i2s_sd_o", exp_q.size()));
    endtask

    task automatic reconfigure(input int res, input logic swap, input int idle_cycles);
        conf_en <= 1'b0;
        repeat (idle_cycles) @(posedge lmmi_clk_i);
        conf_res  <= res_t'(res);
        conf_swap <= swap;
        @(posedge lmmi_clk_i);
        conf_en <= 1'b1;
        @(posedge lmmi_clk_i);
    endtask

    always @(posedge lmmi_clk_i) begin : observe
        logic    fall;
        logic    rise;
        sample_t got;
        fall = sck_q && !i2s_sck_o;
        rise = !sck_q && i2s_sck_o;
        if (!arst_n || !conf_en) begin
            codec_word  = '0;
            codec_bit   = 0;
            left_held   = 1'b0;
            mon_ws      = 1'b0;
            mon_acc     = '0;
            mon_bits    = 0;
            level_known = 1'b0;
            level_len   = 0;
            ws_known    = 1'b0;
            fall_cnt    = 0;
            i2s_sd_i   <= 1'b0;
            if (!arst_n) begin
                slot_count    <= 0;
                words_checked <= 0;
                en_low_cnt     = 0;
            end else begin
                en_low_cnt = en_low_cnt + 1;
            end
            // generator parked, one cycle after it sees enable drop
            if (en_low_cnt >= 2) begin
                assert (!i2s_sck_o && !i2s_ws_o)
                    else fail_now($sformatf("error disabled i2s_sck_o %h i2s_ws_o %h",
                                            i2s_sck_o, i2s_ws_o));
            end
        end else begin
            en_low_cnt = 0;
            // every full sck level is conf_ratio clocks long
            if (i2s_sck_o != sck_q) begin
                if (level_known) begin
                    assert (level_len == int'(conf_ratio))
                        else fail_now($sformatf("error i2s_sck_o level %h clocks, expected %h",
                                                level_len, conf_ratio));
                end
                level_known = 1'b1;
                level_len   = 1;
            end else begin
                level_len = level_len + 1;
            end
            if (i2s_ws_o != ws_q) begin
                assert (fall)
                    else fail_now("i2s_ws_o changed away from a falling edge of i2s_sck_o");
            end
            if (fall) begin
                if (i2s_ws_o != ws_q) begin
                    if (ws_known) begin
                        assert (fall_cnt + 1 == int'(conf_res))
                            else fail_now($sformatf("error i2s_ws_o slot %h bits, expected %h",
                                                    fall_cnt + 1, conf_res));
                    end
                    ws_known = 1'b1;
                    fall_cnt = 0;
                    // LSB of the finished word rides on the ws change
                    i2s_sd_i  <= codec_word[0];
                    codec_word = quiet ? '0 : next_word(conf_res);
                    codec_bit  = int'(conf_res) - 1;
                    queue_expected(codec_word, i2s_ws_o);
                    slot_count <= slot_count + 1;
                end else begin
                    fall_cnt = fall_cnt + 1;
                    i2s_sd_i <= (codec_bit > 0) ? codec_word[codec_bit] : 1'b0;
                    codec_bit = codec_bit - 1;
                end
            end
            if (rise) begin
                if (i2s_ws_o != mon_ws) begin
                    got = {mon_acc[30:0], i2s_sd_o};
                    // partial first slot after enable has the wrong bit count
                    if (mon_bits == int'(conf_res) - 1 && got != '0) begin
                        check_word(got);
                    end
                    mon_acc  = '0;
                    mon_bits = 0;
                end else begin
                    mon_acc  = {mon_acc[30:0], i2s_sd_o};
                    mon_bits = mon_bits + 1;
                end
                mon_ws = i2s_ws_o;
            end
        end
        sck_q = i2s_sck_o;
        ws_q  = i2s_ws_o;
    end

    a_no_overflow: assert property (
        @(posedge lmmi_clk_i) disable iff (!arst_n)
        !overflow
    ) else fail_now($sformatf("error overflow %h during matched-rate loopback", 1'b1));

    initial begin
        #(watchdog_ns);
        fail_now("timeout, the loopback stopped making progress");
    end

    initial begin
        lmmi_clk_i = 1'b0;
        arst_n     = 1'b0;
        conf_res   = res_t'(16);
        conf_ratio = ratio_t'(3);
        conf_swap  = 1'b0;
        conf_en    = 1'b1;
        quiet      = 1'b0;
        // first edge applies the reset, outputs settle after it
        @(posedge lmmi_clk_i);
        repeat (9) begin
            @(posedge lmmi_clk_i);
            check_idle_outputs();
        end
        arst_n <= 1'b1;
        repeat (2) begin
            @(posedge lmmi_clk_i);
            check_idle_outputs();
        end
        run_phase(24);
        reconfigure(24, 1'b0, 4);
        run_phase(24);
        // channel swap
        reconfigure(24, 1'b1, 4);
        run_phase(24);
        // long pause with the generator parked, then resume
        reconfigure(24, 1'b0, 40);
        run_phase(16);
        assert (words_checked >= 60)
            else fail_now("too few words made it around the loop");
        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: i2s_loopback_top.sv
`timescale 1ns/100ps

module i2s_loopback_top
    import i2s_pkg::*;
(
    input  logic   lmmi_clk_i,
    input  logic   arst_n,
    input  res_t   conf_res,
    input  ratio_t conf_ratio,
    input  logic   conf_swap,
    input  logic   conf_en,
    input  logic   i2s_sd_i,
    output logic   i2s_sd_o,
    output logic   i2s_sck_o,
    output logic   i2s_ws_o,
    output logic   overflow
);

    logic    sck_rise;
    logic    sck_fall;
    logic    slot_start;
    logic    wr_valid;
    sample_t wr_data;
    logic    rx_credit;
    logic    rd_valid;
    sample_t rd_data;
    logic    tx_credit;

    // shared bit clock and frame for both directions
    i2s_clock_gen u_clock_gen (
        .lmmi_clk_i (lmmi_clk_i),
        .arst_n     (arst_n),
        .conf_ratio (conf_ratio),
        .conf_res   (conf_res),
        .conf_en    (conf_en),
        .i2s_sck    (i2s_sck_o),
        .sck_rise   (sck_rise),
        .sck_fall   (sck_fall),
        .ws         (i2s_ws_o),
        .slot_start (slot_start)
    );

    i2s_receiver u_receiver (
        .lmmi_clk_i (lmmi_clk_i),
        .arst_n     (arst_n),
        .conf_res   (conf_res),
        .conf_swap  (conf_swap),
        .conf_en    (conf_en),
        .i2s_sd     (i2s_sd_i),
        .sck_rise   (sck_rise),
        .slot_start (slot_start),
        .ws         (i2s_ws_o),
        .wr_valid   (wr_valid),
        .wr_data    (wr_data),
        .rx_credit  (rx_credit),
        .overflow   (overflow)
    );

    sample_buffer u_buffer (
        .lmmi_clk_i (lmmi_clk_i),
        .arst_n     (arst_n),
        .wr_valid   (wr_valid),
        .wr_data    (wr_data),
        .rx_credit  (rx_credit),
        .rd_valid   (rd_valid),
        .rd_data    (rd_data),
        .tx_credit  (tx_credit)
    );

    i2s_transmitter u_transmitter (
        .lmmi_clk_i (lmmi_clk_i),
        .arst_n     (arst_n),
        .conf_res   (conf_res),
        .sck_fall   (sck_fall),
        .slot_start (slot_start),
        .rd_valid   (rd_valid),
        .rd_data    (rd_data),
        .tx_credit  (tx_credit),
        .i2s_sd     (i2s_sd_o)
    );

endmodule

// File: i2s_transmitter.sv
`timescale 1ns/100ps

module i2s_transmitter
    import i2s_pkg::*;
(
    input  logic    lmmi_clk_i,
    input  logic    arst_n,
    input  res_t    conf_res,
    input  logic    sck_fall,
    input  logic    slot_start,
    input  logic    rd_valid,
    input  sample_t rd_data,
    output logic    tx_credit,
    output logic    i2s_sd
);

    tx_state_t state;
    sample_t   hold;
    sample_t   sreg;
    logic      hold_valid;
    res_t      bit_cnt;
    logic      bit_due;

    // MSB goes out in wait_word, then conf_res-1 more bits in shift
    assign bit_due = (state == wait_word) || ((state == shift) && (bit_cnt < conf_res));

    always_ff @(posedge lmmi_clk_i or negedge arst_n) begin
        if (!arst_n) begin
            state      <= idle;
            hold_valid <= 1'b0;
            tx_credit  <= 1'b0;
            i2s_sd     <= 1'b0;
            bit_cnt    <= '0;
        end else begin
            tx_credit <= 1'b0;
            if (rd_valid) begin
                hold_valid <= 1'b1;
            end else if (slot_start && hold_valid) begin
                // held word moves to the shifter, register is free again
                hold_valid <= 1'b0;
                tx_credit  <= 1'b1;
            end
            if (sck_fall) begin
                // pad with zeros past the resolution
                i2s_sd <= bit_due ? sreg[31] : 1'b0;
                if (slot_start) begin
                    state   <= wait_word;
                    bit_cnt <= '0;
                end else begin
                    case (state)
                        wait_word: begin
                            state   <= shift;
                            bit_cnt <= res_t'(1);
                        end
                        shift: begin
                            if (bit_cnt != '1) begin
                                bit_cnt <= bit_cnt + res_t'(1);
                            end
                        end
                        default: begin
                            state <= idle;
                        end
                    endcase
                end
            end
        end
    end

    always_ff @(posedge lmmi_clk_i) begin
        if (rd_valid) begin
            hold <= rd_data;
        end
        // left-align so the MSB sits at bit 31
        if (slot_start) begin
            sreg <= hold_valid ? (hold << (res_t'(32) - conf_res)) : '0;
        end else if (sck_fall && (state != idle)) begin
            sreg <= {sreg[30:0], 1'b0};
        end
    end

    // buffer must honor the single credit
    a_hold_not_overwritten: assert property (
        @(posedge lmmi_clk_i) disable iff (!arst_n)
        rd_valid |-> !hold_valid
    );

endmodule

// File: sample_buffer.sv
`timescale 1ns/100ps

module sample_buffer
    import i2s_pkg::*;
(
    input  logic    lmmi_clk_i,
    input  logic    arst_n,
    input  logic    wr_valid,
    input  sample_t wr_data,
    output logic    rx_credit,
    output logic    rd_valid,
    output sample_t rd_data,
    input  logic    tx_credit
);

    sample_t mem [buf_depth];
    ptr_t    wr_ptr;
    ptr_t    rd_ptr;
    credit_t count;
    logic    tx_cred;
    logic    pop;

    // hand a word over only when the holding register is free
    assign pop      = tx_cred && (count != '0);
    assign rd_valid = pop;
    assign rd_data  = mem[rd_ptr];

    always_ff @(posedge lmmi_clk_i or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            tx_cred   <= 1'b1;
            rx_credit <= 1'b0;
        end else begin
            if (wr_valid) begin
                wr_ptr <= (wr_ptr == ptr_t'(buf_depth - 1)) ? '0 : wr_ptr + ptr_t'(1);
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_t'(buf_depth - 1)) ? '0 : rd_ptr + ptr_t'(1);
            end
            count     <= count + credit_t'(wr_valid) - credit_t'(pop);
            // transmitter credit goes out with a pop and comes back on tx_credit
            tx_cred   <= (tx_cred && !pop) || tx_credit;
            // each freed slot goes back to the receiver
            rx_credit <= pop;
        end
    end

    always_ff @(posedge lmmi_clk_i) begin
        if (wr_valid) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // receiver credits must keep it from overrunning the storage
    a_no_write_full: assert property (
        @(posedge lmmi_clk_i) disable iff (!arst_n)
        wr_valid |-> (count != credit_t'(buf_depth))
    );

    // transmitter only returns a credit it was given
    a_tx_credit_owed: assert property (
        @(posedge lmmi_clk_i) disable iff (!arst_n)
        tx_credit |-> !tx_cred
    );

endmodule

// File: i2s_receiver.sv
`timescale 1ns/100ps

module i2s_receiver
    import i2s_pkg::*;
(
    input  logic    lmmi_clk_i,
    input  logic    arst_n,
    input  res_t    conf_res,
    input  logic    conf_swap,
    input  logic    conf_en,
    input  logic    i2s_sd,
    input  logic    sck_rise,
    input  logic    slot_start,
    input  logic    ws,
    output logic    wr_valid,
    output sample_t wr_data,
    input  logic    rx_credit,
    output logic    overflow
);

    sample_t sreg;
    sample_t hold;
    sample_t word;
    sample_t res_mask;
    sample_t push_data;
    res_t    bit_cnt;
    logic    first_rise;
    logic    hold_valid;
    logic    left_pend;
    logic    word_done;
    logic    push_req;
    credit_t credit_cnt;
    credit_t credit_avail;

    // keep only conf_res low bits
    assign res_mask = (conf_res >= res_t'(32)) ? '1 : (sample_t'(1) << conf_res) - sample_t'(1);

    // the first rise after a ws change carries the LSB of the previous slot
    assign word      = {sreg[30:0], i2s_sd} & res_mask;
    assign word_done = sck_rise && first_rise && (bit_cnt == conf_res - res_t'(1));

    // ws has already flipped, so ws high means a left word just ended
    assign push_req  = conf_en && ((word_done && !(conf_swap && ws)) || left_pend);
    assign push_data = left_pend ? hold : word;

    // a push in flight has already spent its credit
    assign credit_avail = wr_valid ? credit_cnt - credit_t'(1) : credit_cnt;

    always_ff @(posedge lmmi_clk_i or negedge arst_n) begin
        if (!arst_n) begin
            sreg       <= '0;
            bit_cnt    <= '0;
            first_rise <= 1'b0;
            hold_valid <= 1'b0;
            left_pend  <= 1'b0;
            wr_valid   <= 1'b0;
            overflow   <= 1'b0;
            credit_cnt <= credit_t'(buf_depth);
        end else begin
            credit_cnt <= credit_cnt - credit_t'(wr_valid) + credit_t'(rx_credit);
            wr_valid   <= push_req && (credit_avail != '0);
            // no room downstream, word is lost
            overflow   <= push_req && (credit_avail == '0);
            left_pend  <= 1'b0;
            if (!conf_en) begin
                sreg       <= '0;
                bit_cnt    <= '0;
                first_rise <= 1'b0;
                hold_valid <= 1'b0;
            end else begin
                if (slot_start) begin
                    first_rise <= 1'b1;
                end
                if (sck_rise) begin
                    if (first_rise) begin
                        // start the next word from a clean register
                        first_rise <= 1'b0;
                        sreg       <= '0;
                        bit_cnt    <= '0;
                    end else begin
                        sreg <= {sreg[30:0], i2s_sd};
                        if (bit_cnt != '1) begin
                            bit_cnt <= bit_cnt + res_t'(1);
                        end
                    end
                end
                if (word_done) begin
                    if (!conf_swap) begin
                        hold_valid <= 1'b0;
                    end else if (ws) begin
                        // park left until its right partner arrives
                        hold_valid <= 1'b1;
                    end else if (hold_valid) begin
                        hold_valid <= 1'b0;
                        left_pend  <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge lmmi_clk_i) begin
        if (push_req) begin
            wr_data <= push_data;
        end
        if (word_done && conf_swap && ws) begin
            hold <= word;
        end
    end

    // credit protocol toward the sample buffer
    a_push_has_credit: assert property (
        @(posedge lmmi_clk_i) disable iff (!arst_n)
        wr_valid |-> (credit_cnt != '0)
    );

    // the buffer never hands back more than it lent
    a_credit_bounded: assert property (
        @(posedge lmmi_clk_i) disable iff (!arst_n)
        credit_cnt <= credit_t'(buf_depth)
    );

endmodule

// File: i2s_clock_gen.sv
`timescale 1ns/100ps

module i2s_clock_gen
    import i2s_pkg::*;
(
    input  logic   lmmi_clk_i,
    input  logic   arst_n,
    input  ratio_t conf_ratio,
    input  res_t   conf_res,
    input  logic   conf_en,
    output logic   i2s_sck,
    output logic   sck_rise,
    output logic   sck_fall,
    output logic   ws,
    output logic   slot_start
);

    ratio_t div_cnt;
    res_t   bit_cnt;

    always_ff @(posedge lmmi_clk_i or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt    <= '0;
            bit_cnt    <= '0;
            i2s_sck    <= 1'b0;
            ws         <= 1'b0;
            sck_rise   <= 1'b0;
            sck_fall   <= 1'b0;
            slot_start <= 1'b0;
        end else begin
            // strobes last a single cycle
            sck_rise   <= 1'b0;
            sck_fall   <= 1'b0;
            slot_start <= 1'b0;
            if (!conf_en) begin
                // parked with sck and ws low
                div_cnt <= '0;
                bit_cnt <= '0;
                i2s_sck <= 1'b0;
                ws      <= 1'b0;
            end else if (div_cnt >= conf_ratio - ratio_t'(1)) begin
                div_cnt <= '0;
                i2s_sck <= ~i2s_sck;
                if (!i2s_sck) begin
                    sck_rise <= 1'b1;
                end else begin
                    sck_fall <= 1'b1;
                    // last bit of the slot ends here, flip channel
                    if (bit_cnt >= conf_res - res_t'(1)) begin
                        bit_cnt    <= '0;
                        ws         <= ~ws;
                        slot_start <= 1'b1;
                    end else begin
                        bit_cnt <= bit_cnt + res_t'(1);
                    end
                end
            end else begin
                div_cnt <= div_cnt + ratio_t'(1);
            end
        end
    end

    // bit counter stays inside the slot, so ws keeps a conf_res period
    a_bit_cnt_in_slot: assert property (
        @(posedge lmmi_clk_i) disable iff (!arst_n)
        (conf_res != '0) |-> (bit_cnt < conf_res)
    );

endmodule

// File: i2s_pkg.sv
package i2s_pkg;

    // one channel word, right-justified to the resolution
    typedef logic [31:0] sample_t;

    // bits per channel, legal range 1 to 32
    typedef logic [5:0] res_t;

    // lmmi_clk_i cycles per half bit-clock period
    typedef logic [9:0] ratio_t;

    // buffer depth, also the receiver's credit after reset
    localparam int unsigned buf_depth = 4;

    // counts 0 up to buf_depth
    typedef logic [2:0] credit_t;

    // fifo pointer
    typedef logic [$clog2(buf_depth)-1:0] ptr_t;

    // transmitter shift engine
    typedef enum logic [1:0] {
        idle,
        wait_word,
        shift
    } tx_state_t;

endpackage
